// File: conv_data_pkg.sv
package conv_data_pkg;

	localparam int MIN_DIM   = 3;
	localparam int MEM_DEPTH = 512;

	typedef logic        [7:0]  pixel_t;
	typedef logic signed [7:0]  coef_t;
	typedef logic signed [19:0] acc_t;  // nine products, no overflow
	typedef logic        [5:0]  col_t;
	typedef logic        [4:0]  row_t;
	typedef logic        [8:0]  mem_addr_t;  // row * 32 + col
	typedef logic        [1:0]  slot_t;  // window row

	localparam col_t MAX_W = 6'd32;
	localparam row_t MAX_H = 5'd16;

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		DRAIN,
		FINISH
	} seq_state_e;

	// strobes into the window, aligned with image read data
	typedef struct packed {
		logic      take;
		slot_t     slot;
		logic      shift;
		logic      emit;
		mem_addr_t res_addr;
	} win_ctl_t;

endpackage

// File: conv_cfg_pkg.sv
package conv_cfg_pkg;

	typedef logic [12:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	localparam apb_addr_t REG_CTRL      = 13'h000;
	localparam apb_addr_t REG_STATUS    = 13'h004;
	localparam apb_addr_t REG_DIM       = 13'h008;
	localparam apb_addr_t REG_COEF_BASE = 13'h020;
	localparam apb_addr_t IMG_BASE      = 13'h0800;
	localparam apb_addr_t RES_BASE      = 13'h1000;

	localparam int NUM_COEF   = 9;
	localparam int CTRL_START = 0;
	localparam int STAT_BUSY  = 0;
	localparam int STAT_DONE  = 1;
	localparam int DIM_W_LSB  = 0;
	localparam int DIM_H_LSB  = 16;

	// coef[0] is the top-left tap, raster order
	typedef struct packed {
		conv_data_pkg::col_t                 width;
		conv_data_pkg::row_t                 height;
		conv_data_pkg::coef_t [NUM_COEF-1:0] coef;
	} conv_cfg_t;

endpackage

// File: conv_frame_mem.sv
`timescale 1ns/1ps

module conv_frame_mem #(
	parameter int DEPTH = conv_data_pkg::MEM_DEPTH,
	parameter int WIDTH = 8
) (
	input  logic                     clk,
	input  logic                     wr_en,
	input  conv_data_pkg::mem_addr_t wr_addr,
	input  logic [WIDTH-1:0]         wr_data,
	input  conv_data_pkg::mem_addr_t rd_addr,
	output logic [WIDTH-1:0]         rd_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];  // one cycle read latency
	end

endmodule

// File: conv_apb_regs.sv
`timescale 1ns/1ps

module conv_apb_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  conv_cfg_pkg::apb_addr_t  paddr,
	input  conv_cfg_pkg::apb_data_t  pwdata,
	output conv_cfg_pkg::apb_data_t  prdata,
	output logic                     pready,
	output logic                     pslverr,
	output conv_cfg_pkg::conv_cfg_t  cfg,
	output logic                     start,
	input  logic                     busy,
	input  logic                     done,
	output logic                     img_wr_en,
	output conv_data_pkg::mem_addr_t img_wr_addr,
	output conv_data_pkg::pixel_t    img_wr_data,
	output conv_data_pkg::mem_addr_t res_rd_addr,
	input  conv_data_pkg::pixel_t    res_rd_data
);

	logic                    access;
	logic                    wr;
	logic                    sel_ctrl, sel_status, sel_dim, sel_coef, sel_img, sel_res;
	logic                    mapped;
	logic                    res_wait;  // second access cycle of a result read
	logic                    start_req, start_err, dim_ok, cfg_lock;
	logic                    done_bit;
	conv_cfg_pkg::apb_addr_t coef_off;
	logic [3:0]              coef_idx;
	conv_data_pkg::coef_t    coef_rd;

	assign access = psel & penable;

	assign coef_off   = paddr - conv_cfg_pkg::REG_COEF_BASE;
	assign coef_idx   = coef_off[5:2];
	assign sel_ctrl   = paddr == conv_cfg_pkg::REG_CTRL;
	assign sel_status = paddr == conv_cfg_pkg::REG_STATUS;
	assign sel_dim    = paddr == conv_cfg_pkg::REG_DIM;
	assign sel_coef   = coef_off < 13'(4 * conv_cfg_pkg::NUM_COEF) && paddr[1:0] == 2'b00;
	assign sel_img    = paddr[12:11] == conv_cfg_pkg::IMG_BASE[12:11];
	assign sel_res    = paddr[12:11] == conv_cfg_pkg::RES_BASE[12:11];
	assign mapped     = sel_ctrl | sel_status | sel_dim | sel_coef | sel_img | sel_res;

	// result reads wait one cycle for the memory
	assign pready = access & ~(sel_res & ~pwrite & ~res_wait);
	assign wr     = pready & pwrite;

	assign cfg_lock  = busy | start;
	assign dim_ok    = cfg.width >= conv_data_pkg::col_t'(conv_data_pkg::MIN_DIM) &&
	                   cfg.width <= conv_data_pkg::MAX_W &&
	                   cfg.height >= conv_data_pkg::row_t'(conv_data_pkg::MIN_DIM) &&
	                   cfg.height <= conv_data_pkg::MAX_H;
	assign start_req = wr & sel_ctrl & pwdata[conv_cfg_pkg::CTRL_START];
	assign start_err = start_req & (cfg_lock | ~dim_ok);
	assign pslverr   = pready & (~mapped | start_err);

	assign img_wr_en   = wr & sel_img;
	assign img_wr_addr = paddr[10:2];
	assign img_wr_data = pwdata[7:0];
	assign res_rd_addr = paddr[10:2];

	assign coef_rd = cfg.coef[coef_idx];

	always_comb begin
		prdata = '0;
		if (sel_status) begin
			prdata[conv_cfg_pkg::STAT_BUSY] = busy;
			prdata[conv_cfg_pkg::STAT_DONE] = done_bit;
		end else if (sel_dim) begin
			prdata[conv_cfg_pkg::DIM_W_LSB +: $bits(conv_data_pkg::col_t)] = cfg.width;
			prdata[conv_cfg_pkg::DIM_H_LSB +: $bits(conv_data_pkg::row_t)] = cfg.height;
		end else if (sel_coef) begin
			prdata = {{24{coef_rd[7]}}, coef_rd};  // sign extended
		end else if (sel_res) begin
			prdata = {24'd0, res_rd_data};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg      <= '0;
			start    <= 1'b0;
			done_bit <= 1'b0;
			res_wait <= 1'b0;
		end else begin
			start    <= start_req & ~start_err;
			res_wait <= access & sel_res & ~pwrite & ~res_wait;
			if (start_req & ~start_err)
				done_bit <= 1'b0;  // new run wins over a late done
			else if (done)
				done_bit <= 1'b1;
			if (wr & ~cfg_lock) begin
				if (sel_dim) begin
					cfg.width  <= pwdata[conv_cfg_pkg::DIM_W_LSB +: $bits(conv_data_pkg::col_t)];
					cfg.height <= pwdata[conv_cfg_pkg::DIM_H_LSB +: $bits(conv_data_pkg::row_t)];
				end
				if (sel_coef)
					cfg.coef[coef_idx] <= pwdata[7:0];
			end
		end
	end

endmodule

// File: conv_scan_seq.sv
`timescale 1ns/1ps

module conv_scan_seq (
	input  logic                     clk,
	input  logic                     rst_n,
	input  conv_cfg_pkg::conv_cfg_t  cfg,
	input  logic                     start,
	output logic                     busy,
	output logic                     done,
	output conv_data_pkg::mem_addr_t img_rd_addr,
	output conv_data_pkg::win_ctl_t  win_ctl
);

	conv_data_pkg::seq_state_e state, next;
	conv_data_pkg::row_t       row;
	conv_data_pkg::col_t       col;
	conv_data_pkg::slot_t      slot;
	conv_data_pkg::row_t       rd_row;
	logic                      last_slot, last_col, last_row;
	conv_data_pkg::win_ctl_t   ctl_now;

	function automatic conv_data_pkg::mem_addr_t pix_addr(
		input conv_data_pkg::row_t r,
		input conv_data_pkg::col_t c
	);
		return conv_data_pkg::mem_addr_t'(r) * conv_data_pkg::mem_addr_t'(conv_data_pkg::MAX_W) +
		       conv_data_pkg::mem_addr_t'(c);
	endfunction

	assign last_slot = slot == 2'd2;
	assign last_col  = col == cfg.width - 6'd1;
	assign last_row  = row == cfg.height - conv_data_pkg::row_t'(conv_data_pkg::MIN_DIM);

	assign rd_row      = row + conv_data_pkg::row_t'(slot);
	assign img_rd_addr = pix_addr(rd_row, col);

	assign busy = state == conv_data_pkg::FETCH || state == conv_data_pkg::DRAIN;
	assign done = state == conv_data_pkg::FINISH;

	always_comb begin
		next = state;
		case (state)
			conv_data_pkg::IDLE:
				if (start)
					next = conv_data_pkg::FETCH;
			conv_data_pkg::FETCH:
				if (last_slot && last_col && last_row)
					next = conv_data_pkg::DRAIN;
			conv_data_pkg::DRAIN:
				if (slot == 2'd1)
					next = conv_data_pkg::FINISH;  // two cycles to flush the MAC
			conv_data_pkg::FINISH:
				next = conv_data_pkg::IDLE;
			default:
				next = conv_data_pkg::IDLE;
		endcase
	end

	// strobes for the read issued this cycle
	always_comb begin
		ctl_now          = '0;
		ctl_now.take     = state == conv_data_pkg::FETCH;
		ctl_now.slot     = slot;
		ctl_now.shift    = ctl_now.take && last_slot;
		ctl_now.emit     = ctl_now.shift && col >= 6'd2;
		ctl_now.res_addr = pix_addr(row, col - 6'd2);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= conv_data_pkg::IDLE;
			row     <= '0;
			col     <= '0;
			slot    <= '0;
			win_ctl <= '0;
		end else begin
			state   <= next;
			win_ctl <= ctl_now;  // line up with read data
			case (state)
				conv_data_pkg::IDLE: begin
					row  <= '0;
					col  <= '0;
					slot <= '0;
				end
				conv_data_pkg::FETCH: begin
					if (!last_slot) begin
						slot <= slot + 2'd1;
					end else begin
						slot <= '0;
						if (!last_col) begin
							col <= col + 6'd1;
						end else begin
							col <= '0;
							if (!last_row)
								row <= row + 5'd1;
						end
					end
				end
				conv_data_pkg::DRAIN: begin
					if (next == conv_data_pkg::FINISH)
						slot <= '0;
					else
						slot <= slot + 2'd1;  // drain cycle count
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// File: conv_window_mac.sv
`timescale 1ns/1ps

module conv_window_mac (
	input  logic                     clk,
	input  logic                     rst_n,
	input  conv_cfg_pkg::conv_cfg_t  cfg,
	input  conv_data_pkg::win_ctl_t  win_ctl,
	input  conv_data_pkg::pixel_t    pix,
	output logic                     res_wr_en,
	output conv_data_pkg::mem_addr_t res_wr_addr,
	output conv_data_pkg::pixel_t    res_wr_data
);

	conv_data_pkg::pixel_t win [3][3];  // [row][col], col 2 is newest
	conv_data_pkg::pixel_t nxt [3][3];
	conv_data_pkg::pixel_t col_buf [2];
	conv_data_pkg::acc_t   sum;
	conv_data_pkg::pixel_t sat;

	// window after this cycle's shift
	always_comb begin
		for (int r = 0; r < 3; r++) begin
			nxt[r][0] = win[r][1];
			nxt[r][1] = win[r][2];
		end
		nxt[0][2] = col_buf[0];
		nxt[1][2] = col_buf[1];
		nxt[2][2] = pix;  // third pixel goes straight in
	end

	always_comb begin
		sum = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				sum = sum + conv_data_pkg::acc_t'(cfg.coef[r * 3 + c]) *
				            conv_data_pkg::acc_t'({1'b0, nxt[r][c]});
			end
		end
	end

	always_comb begin
		if (sum < 0)
			sat = '0;
		else if (sum > conv_data_pkg::acc_t'(255))
			sat = 8'hff;
		else
			sat = sum[7:0];
	end

	always_ff @(posedge clk) begin
		if (win_ctl.take && win_ctl.slot != 2'd2)
			col_buf[win_ctl.slot[0]] <= pix;
		if (win_ctl.shift)
			win <= nxt;
		if (win_ctl.emit) begin
			res_wr_addr <= win_ctl.res_addr;
			res_wr_data <= sat;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			res_wr_en <= 1'b0;
		else
			res_wr_en <= win_ctl.emit;  // write the cycle after emit
	end

endmodule

// File: conv_top.sv
`timescale 1ns/1ps

module conv_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  conv_cfg_pkg::apb_addr_t paddr,
	input  conv_cfg_pkg::apb_data_t pwdata,
	output conv_cfg_pkg::apb_data_t prdata,
	output logic                    pready,
	output logic                    pslverr
);

	conv_cfg_pkg::conv_cfg_t  cfg;
	logic                     start;
	logic                     busy;
	logic                     done;
	logic                     img_wr_en;
	conv_data_pkg::mem_addr_t img_wr_addr;
	conv_data_pkg::pixel_t    img_wr_data;
	conv_data_pkg::mem_addr_t img_rd_addr;
	conv_data_pkg::pixel_t    pix;
	conv_data_pkg::win_ctl_t  win_ctl;
	logic                     res_wr_en;
	conv_data_pkg::mem_addr_t res_wr_addr;
	conv_data_pkg::pixel_t    res_wr_data;
	conv_data_pkg::mem_addr_t res_rd_addr;
	conv_data_pkg::pixel_t    res_rd_data;

	conv_apb_regs u_apb_regs (.*);

	conv_scan_seq u_scan_seq (.*);

	conv_window_mac u_window_mac (.*);

	conv_frame_mem #(
		.DEPTH (conv_data_pkg::MEM_DEPTH),
		.WIDTH ($bits(conv_data_pkg::pixel_t))
	) u_img_mem (
		.clk     (clk),
		.wr_en   (img_wr_en),
		.wr_addr (img_wr_addr),
		.wr_data (img_wr_data),
		.rd_addr (img_rd_addr),
		.rd_data (pix)
	);

	conv_frame_mem #(
		.DEPTH (conv_data_pkg::MEM_DEPTH),
		.WIDTH ($bits(conv_data_pkg::pixel_t))
	) u_res_mem (
		.clk     (clk),
		.wr_en   (res_wr_en),
		.wr_addr (res_wr_addr),
		.wr_data (res_wr_data),
		.rd_addr (res_rd_addr),
		.rd_data (res_rd_data)
	);

endmodule

// File: conv_tb_checker.sv
`timescale 1ns/1ps

module conv_tb_checker (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    psel,
	input logic                    penable,
	input logic                    pwrite,
	input conv_cfg_pkg::apb_addr_t paddr,
	input logic                    pready,
	input logic                    pslverr,
	input logic                    start,
	input logic                    busy,
	input logic                    done
);

	a_slverr_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> pready)
		else $error("pslverr high while pready is low");

	// master holds the transfer until pready
	a_hold_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
		psel && penable && !pready |=> $stable(paddr) && $stable(pwrite))
		else $error("paddr or pwrite changed during a wait state");

	a_busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
		start |=> busy)
		else $error("busy not set on the cycle after an accepted start");

	a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		!(done && busy))
		else $error("done and busy set together");

endmodule

// File: conv_tb.sv
`timescale 1ns/1ps

module conv_tb;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 16;
	localparam int IMG_W        = int'(conv_data_pkg::MAX_W);
	localparam int IMG_H        = int'(conv_data_pkg::MAX_H);

	logic                    clk;
	logic                    rst_n;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	conv_cfg_pkg::apb_addr_t paddr;
	conv_cfg_pkg::apb_data_t pwdata;
	conv_cfg_pkg::apb_data_t prdata;
	logic                    pready;
	logic                    pslverr;

	conv_data_pkg::pixel_t img [IMG_H][IMG_W];  // copy of the image memory
	conv_data_pkg::coef_t  coef [9];
	string                 test_name;
	int                    mismatches;
	int                    other_errs;
	int                    clamp_lo;
	int                    clamp_hi;

	conv_top u_dut (.*);

	bind conv_top conv_tb_checker u_checker (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pready  (pready),
		.pslverr (pslverr),
		.start   (start),
		.busy    (busy),
		.done    (u_apb_regs.done_bit)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// scan time plus APB traffic of one run, in cycles
	function automatic int run_cycles(input int w, input int h);
		return 3 * w * h + 4 * (w * h + (w - 2) * (h - 2) + 40);
	endfunction

	function automatic conv_cfg_pkg::apb_addr_t pix_offset(input int r, input int c);
		return conv_cfg_pkg::apb_addr_t'(4 * (r * IMG_W + c));
	endfunction

	function automatic int ref_conv(input int r, input int c);
		int acc;
		acc = 0;
		for (int i = 0; i < 3; i++)
			for (int j = 0; j < 3; j++)
				acc += int'(coef[i * 3 + j]) * int'(img[r + i][c + j]);
		if (acc < 0)
			return 0;
		if (acc > 255)
			return 255;
		return acc;
	endfunction

	task automatic check_value(input string what, input int exp, input int act);
		assert (act == exp) else begin
			mismatches++;
			$display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic apb_xfer(input logic write, input conv_cfg_pkg::apb_addr_t addr,
			input conv_cfg_pkg::apb_data_t data, output conv_cfg_pkg::apb_data_t rdata,
			output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);  // wait states
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input conv_cfg_pkg::apb_addr_t addr,
			input conv_cfg_pkg::apb_data_t data, input logic exp_err);
		conv_cfg_pkg::apb_data_t rd;
		logic                    err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_value($sformatf("pslverr on write 0x%h", addr), int'(exp_err), int'(err));
	endtask

	task automatic apb_read(input conv_cfg_pkg::apb_addr_t addr,
			output conv_cfg_pkg::apb_data_t data, input logic exp_err);
		logic err;
		apb_xfer(1'b0, addr, '0, data, err);
		check_value($sformatf("pslverr on read 0x%h", addr), int'(exp_err), int'(err));
	endtask

	task automatic set_dims(input int w, input int h);
		apb_write(conv_cfg_pkg::REG_DIM, conv_cfg_pkg::apb_data_t'((h << 16) | w), 1'b0);
	endtask

	task automatic randomize_coefs();
		for (int i = 0; i < 9; i++)
			coef[i] = conv_data_pkg::coef_t'($urandom_range(255, 0));
	endtask

	task automatic load_coefs();
		for (int i = 0; i < 9; i++)
			apb_write(conv_cfg_pkg::REG_COEF_BASE + conv_cfg_pkg::apb_addr_t'(4 * i),
				{24'd0, coef[i]}, 1'b0);
	endtask

	task automatic load_image(input int w, input int h);
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				img[r][c] = conv_data_pkg::pixel_t'($urandom());
				apb_write(conv_cfg_pkg::IMG_BASE + pix_offset(r, c), {24'd0, img[r][c]}, 1'b0);
			end
		end
	endtask

	task automatic start_run(input logic exp_err);
		apb_write(conv_cfg_pkg::REG_CTRL, 32'd1, exp_err);
	endtask

	task automatic check_status(input int exp_busy, input int exp_done);
		conv_cfg_pkg::apb_data_t rd;
		apb_read(conv_cfg_pkg::REG_STATUS, rd, 1'b0);
		check_value("busy", exp_busy, int'(rd[conv_cfg_pkg::STAT_BUSY]));
		check_value("done", exp_done, int'(rd[conv_cfg_pkg::STAT_DONE]));
	endtask

	task automatic wait_done(input int w, input int h);
		conv_cfg_pkg::apb_data_t rd;
		int                      polls;
		polls = 0;
		rd    = '0;
		while (!rd[conv_cfg_pkg::STAT_DONE] && polls < run_cycles(w, h)) begin
			apb_read(conv_cfg_pkg::REG_STATUS, rd, 1'b0);
			polls++;
		end
		assert (rd[conv_cfg_pkg::STAT_DONE]) else begin
			other_errs++;
			$display("%s: done bit never set after %0d status reads", test_name, polls);
		end
	endtask

	task automatic check_results(input int w, input int h);
		conv_cfg_pkg::apb_data_t rd;
		int                      exp;
		for (int r = 0; r < h - 2; r++) begin
			for (int c = 0; c < w - 2; c++) begin
				exp = ref_conv(r, c);
				if (exp == 0)
					clamp_lo++;
				if (exp == 255)
					clamp_hi++;
				apb_read(conv_cfg_pkg::RES_BASE + pix_offset(r, c), rd, 1'b0);
				check_value($sformatf("result (%0d,%0d)", r, c), exp, int'(rd));
			end
		end
	endtask

	task automatic prepare_run(input int w, input int h);
		set_dims(w, h);
		load_coefs();
		load_image(w, h);
	endtask

	task automatic finish_run(input int w, input int h);
		wait_done(w, h);
		check_status(0, 1);
		check_results(w, h);
	endtask

	task automatic run_conv(input int w, input int h);
		prepare_run(w, h);
		start_run(1'b0);
		finish_run(w, h);
	endtask

	initial begin : watchdog
		longint limit;
		limit = 2 * (RESET_CYCLES + 200 + 2 * run_cycles(8, 6) + run_cycles(12, 9) +
			run_cycles(16, 10) + run_cycles(7, 5) + run_cycles(3, 3) +
			run_cycles(32, 16) + run_cycles(20, 12));
		#(limit * CLK_PERIOD);
		$display("timeout: tests did not finish within %0d cycles", limit);
		$display("Simulation failed");
		$finish;
	end

	initial begin : main
		conv_cfg_pkg::apb_data_t rd;
		void'($urandom(32'h6ae0_261c));
		mismatches = 0;
		other_errs = 0;
		clamp_lo   = 0;
		clamp_hi   = 0;
		rst_n      = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "register readback";
		check_status(0, 0);
		set_dims(13, 7);
		apb_read(conv_cfg_pkg::REG_DIM, rd, 1'b0);
		check_value("dim", (7 << 16) | 13, int'(rd));
		randomize_coefs();
		load_coefs();
		for (int i = 0; i < 9; i++) begin
			apb_read(conv_cfg_pkg::REG_COEF_BASE + conv_cfg_pkg::apb_addr_t'(4 * i), rd, 1'b0);
			check_value($sformatf("coef %0d", i), int'(coef[i]), int'(rd));  // sign extended
		end

		test_name = "identity kernel";
		for (int i = 0; i < 9; i++)
			coef[i] = (i == 4) ? 8'sd1 : 8'sd0;
		run_conv(8, 6);
		start_run(1'b0);
		apb_read(conv_cfg_pkg::REG_STATUS, rd, 1'b0);
		check_value("done after restart", 0, int'(rd[conv_cfg_pkg::STAT_DONE]));
		wait_done(8, 6);

		test_name = "random kernels";
		clamp_lo  = 0;
		clamp_hi  = 0;
		randomize_coefs();
		run_conv(12, 9);
		randomize_coefs();
		run_conv(16, 10);
		randomize_coefs();
		run_conv(7, 5);
		assert (clamp_lo > 0 && clamp_hi > 0) else begin
			other_errs++;
			$display("%s: results never reached both 0 and 255", test_name);
		end

		test_name = "size extremes";
		randomize_coefs();
		run_conv(3, 3);
		randomize_coefs();
		run_conv(32, 16);

		test_name = "errors";
		set_dims(2, 8);
		start_run(1'b1);
		check_status(0, 1);  // done kept from the last run
		set_dims(8, 17);
		start_run(1'b1);
		check_status(0, 1);
		apb_write(13'h044, 32'd0, 1'b1);
		apb_read(13'h010, rd, 1'b1);
		randomize_coefs();
		prepare_run(20, 12);
		start_run(1'b0);
		start_run(1'b1);  // already busy
		check_status(1, 0);
		set_dims(5, 5);  // ignored while busy
		apb_write(conv_cfg_pkg::REG_COEF_BASE, 32'h55, 1'b0);
		apb_read(13'h044, rd, 1'b1);
		finish_run(20, 12);
		apb_read(conv_cfg_pkg::REG_DIM, rd, 1'b0);
		check_value("dim after run", (12 << 16) | 20, int'(rd));

		$display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
		if (mismatches == 0 && other_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: flist.f
conv_data_pkg.sv
conv_cfg_pkg.sv
conv_frame_mem.sv
conv_apb_regs.sv
conv_scan_seq.sv
conv_window_mac.sv
conv_top.sv
conv_tb_checker.sv
conv_tb.sv

// File: Makefile
# Verilator build and run of the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= conv_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "result: PASS" || \
		(echo "result: FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
